//--- filelist.f
src/piton_l15_pkg.sv
src/l15_fifo.sv
src/l15_req_arbiter.sv
src/l15_ret_router.sv
src/l15_transducer_top.sv
verification/tb_checker.sv
verification/l15_assertions.sv
verification/tb_top.sv

//--- Makefile
SRCS := $(wildcard src/*.sv) $(wildcard verification/*.sv)

.PHONY: all run clean

all: obj_dir/Vtb_top

obj_dir/Vtb_top: $(SRCS) filelist.f
	verilator --binary --timing --assert -Wno-fatal --top-module tb_top \
		-Mdir obj_dir -f filelist.f

run: obj_dir/Vtb_top
	@out="$$(./obj_dir/Vtb_top)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST RESULT: PASS$$"

clean:
	rm -rf obj_dir

//--- verification/tb_top.sv
`timescale 1ns/1ns

module tb_top;

  typedef struct {
    int                          num;
    logic [1:0]                  req_mask;
    int                          req_cnt;
    int                          ack_delay;  // negative means random 0..3
    int                          ack_hold;
    int                          ret_cnt;
    piton_l15_pkg::l15_rtntype_t ret_type;
    logic [1:0]                  ret_route;  // engines that should see the returns
    int                          yumi_hold;
    logic [1:0]                  yumi_mask;
  } row_t;

  localparam int NUM_ROWS = 11;
  localparam int CYCLE_LIMIT = NUM_ROWS * 64 + 20;

  logic                          clk_i;
  logic                          rst_n_i;
  piton_l15_pkg::l15_req_t [1:0] engine_req_i;
  logic [1:0]                    engine_req_v_i;
  logic [1:0]                    engine_req_ready_o;
  piton_l15_pkg::l15_req_t       l15_req_o;
  logic                          l15_val_o;
  logic                          l15_ack_i;
  piton_l15_pkg::l15_ret_t       l15_ret_i;
  logic                          l15_val_i;
  logic                          l15_req_ack_o;
  piton_l15_pkg::l15_ret_t       engine_ret_o;
  logic [1:0]                    engine_ret_v_o;
  logic [1:0]                    engine_ret_yumi_i;

  row_t        rows [NUM_ROWS];
  logic [31:0] lfsr = 32'h885732e1;
  int          cycles = 0;
  int          ack_delay_cfg = 0;
  int          ack_wait = 0;
  logic        ack_block = 1'b0;

  l15_transducer_top dut_i (.*);

  tb_checker u_checker (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Galois LFSR, one step per bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      v = {v[62:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic piton_l15_pkg::l15_req_t make_req();
    piton_l15_pkg::l15_req_t r;
    {r.rqtype, r.nc, r.size} = 9'(rand_bits(9));
    r.address = piton_l15_pkg::l15_addr_t'(rand_bits(40));
    r.data    = rand_bits(64);
    {r.l1rplway, r.amo_op} = 6'(rand_bits(6));
    return r;
  endfunction

  function automatic piton_l15_pkg::l15_ret_t make_ret(input piton_l15_pkg::l15_rtntype_t t);
    piton_l15_pkg::l15_ret_t r;
    r.rtntype = t;
    {r.noncacheable, r.atomic, r.threadid} = 3'(rand_bits(3));
    r.data_0  = rand_bits(64);
    r.data_1  = rand_bits(64);
    r.data_2  = rand_bits(64);
    r.data_3  = rand_bits(64);
    {r.inval_address_15_4, r.inval_icache_inval, r.inval_dcache_inval,
     r.inval_icache_all_way, r.inval_dcache_all_way, r.inval_way} = 18'(rand_bits(18));
    return r;
  endfunction

  function automatic int draw_delay();
    return (ack_delay_cfg < 0) ? int'(rand_bits(2)) : ack_delay_cfg;
  endfunction

  // L1.5 side, acks the offered request after a delay
  always @(posedge clk_i) begin
    if (l15_ack_i) begin
      l15_ack_i <= 1'b0;
      ack_wait <= draw_delay();
    end else if (l15_val_o && !ack_block) begin
      if (ack_wait == 0) l15_ack_i <= 1'b1;
      else ack_wait <= ack_wait - 1;
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  task automatic send_requests(input int e, input int cnt);
    for (int k = 0; k < cnt; k++) begin
      engine_req_v_i[e] <= 1'b1;
      engine_req_i[e] <= make_req();
      @(posedge clk_i);
      while (!engine_req_ready_o[e]) @(posedge clk_i);
    end
    engine_req_v_i[e] <= 1'b0;
  endtask

  task automatic send_returns(input int cnt, input piton_l15_pkg::l15_rtntype_t t);
    for (int k = 0; k < cnt; k++) begin
      l15_val_i <= 1'b1;
      l15_ret_i <= make_ret(t);
      @(posedge clk_i);
      while (!l15_req_ack_o) @(posedge clk_i);
    end
    l15_val_i <= 1'b0;
  endtask

  task automatic run_row(input row_t r);
    ack_delay_cfg = r.ack_delay;
    ack_wait = draw_delay();
    ack_block <= (r.ack_hold > 0);
    u_checker.expect_route(r.ret_route);
    fork
      if (r.req_mask[0]) send_requests(piton_l15_pkg::ENGINE_ICACHE, r.req_cnt);
      if (r.req_mask[1]) send_requests(piton_l15_pkg::ENGINE_DCACHE, r.req_cnt);
      if (r.ret_cnt > 0) send_returns(r.ret_cnt, r.ret_type);
      begin
        engine_ret_yumi_i <= 2'b00;
        repeat (r.yumi_hold) @(posedge clk_i);
        engine_ret_yumi_i <= r.yumi_mask;
      end
      begin
        repeat (r.ack_hold) @(posedge clk_i);
        ack_block <= 1'b0;
      end
    join
    @(posedge clk_i);
    while (l15_val_o || (|engine_ret_v_o)) @(posedge clk_i);
    @(negedge clk_i);
    u_checker.end_test(r.num);
    @(posedge clk_i);
  endtask

  initial begin
    rows[0]  = '{1, 2'b01, 1, -1, 0, 0, piton_l15_pkg::RTN_LOAD, 2'b10, 0, 2'b11};
    rows[1]  = '{2, 2'b11, 6, -1, 0, 0, piton_l15_pkg::RTN_LOAD, 2'b10, 0, 2'b11};
    rows[2]  = '{3, 2'b11, 4, 0, 20, 0, piton_l15_pkg::RTN_LOAD, 2'b10, 0, 2'b11};
    rows[3]  = '{4, 2'b00, 0, 0, 0, 1, piton_l15_pkg::RTN_LOAD, 2'b10, 0, 2'b11};
    rows[4]  = '{5, 2'b00, 0, 0, 0, 1, piton_l15_pkg::RTN_IFILL, 2'b01, 0, 2'b11};
    rows[5]  = '{6, 2'b00, 0, 0, 0, 1, piton_l15_pkg::RTN_EVICT, 2'b11, 2, 2'b01};
    rows[6]  = '{7, 2'b00, 0, 0, 0, 1, piton_l15_pkg::RTN_INT, 2'b11, 2, 2'b10};
    rows[7]  = '{8, 2'b00, 0, 0, 0, 1, piton_l15_pkg::RTN_ST_ACK, 2'b10, 0, 2'b11};
    rows[8]  = '{9, 2'b00, 0, 0, 0, 1, piton_l15_pkg::RTN_ATOMIC, 2'b10, 0, 2'b11};
    rows[9]  = '{10, 2'b00, 0, 0, 0, 17, piton_l15_pkg::RTN_LOAD, 2'b10, 24, 2'b11};
    rows[10] = '{11, 2'b11, 3, -1, 0, 4, piton_l15_pkg::RTN_EVICT, 2'b11, 3, 2'b11};

    rst_n_i = 1'b0;
    engine_req_i = '0;
    engine_req_v_i = 2'b00;
    l15_ack_i = 1'b0;
    l15_ret_i = '0;
    l15_val_i = 1'b0;
    engine_ret_yumi_i = 2'b00;
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);

    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(rows[i]);
    end

    u_checker.print_summary();
    if (u_checker.error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- verification/l15_assertions.sv
`timescale 1ns/1ns

module l15_assertions (
  input logic                          clk_i,
  input logic                          rst_n_i,
  input piton_l15_pkg::l15_req_t       l15_req_o,
  input logic                          l15_val_o,
  input logic                          l15_ack_i,
  input logic                          l15_val_i,
  input logic                          l15_req_ack_o,
  input logic [1:0]                    engine_req_ready_o,
  input logic [1:0]                    req_head_v,
  input logic [1:0]                    req_yumi,
  input logic [1:0]                    engine_ret_v_o,
  input logic                          ret_head_v
);

  // A dcache grant cannot be displaced, so it holds until ack
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    l15_val_o && !l15_ack_i && req_head_v[piton_l15_pkg::ENGINE_DCACHE]
    |=> l15_val_o && $stable(l15_req_o))
    else $error("request changed before ack");

  a_ack_needs_val: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    l15_req_ack_o |-> l15_val_i)
    else $error("return ack without return valid");

  // A full queue stays full until its head is popped
  a_full_holds_i: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(rst_n_i) && !engine_req_ready_o[0] && !req_yumi[0] |=> !engine_req_ready_o[0])
    else $error("icache request accepted while ready was low");

  a_full_holds_d: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(rst_n_i) && !engine_req_ready_o[1] && !req_yumi[1] |=> !engine_req_ready_o[1])
    else $error("dcache request accepted while ready was low");

  a_ret_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !ret_head_v |-> engine_ret_v_o == 2'b00)
    else $error("return valid with an empty return queue");

endmodule

bind l15_transducer_top l15_assertions u_assertions (
  .clk_i              (clk_i),
  .rst_n_i            (rst_n_i),
  .l15_req_o          (l15_req_o),
  .l15_val_o          (l15_val_o),
  .l15_ack_i          (l15_ack_i),
  .l15_val_i          (l15_val_i),
  .l15_req_ack_o      (l15_req_ack_o),
  .engine_req_ready_o (engine_req_ready_o),
  .req_head_v         (req_head_v),
  .req_yumi           (req_yumi),
  .engine_ret_v_o     (engine_ret_v_o),
  .ret_head_v         (ret_head_v)
);

//--- verification/tb_checker.sv
`timescale 1ns/1ns

module tb_checker (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  piton_l15_pkg::l15_req_t [1:0]           engine_req_i,
  input  logic [1:0]                              engine_req_v_i,
  input  logic [1:0]                              engine_req_ready_o,
  input  piton_l15_pkg::l15_req_t                 l15_req_o,
  input  logic                                    l15_val_o,
  input  logic                                    l15_ack_i,
  input  piton_l15_pkg::l15_ret_t                 l15_ret_i,
  input  logic                                    l15_val_i,
  input  logic                                    l15_req_ack_o,
  input  piton_l15_pkg::l15_ret_t                 engine_ret_o,
  input  logic [1:0]                              engine_ret_v_o,
  input  logic [1:0]                              engine_ret_yumi_i
);

  // Reference copies of the three queues
  piton_l15_pkg::l15_req_t icache_q[$];
  piton_l15_pkg::l15_req_t dcache_q[$];
  piton_l15_pkg::l15_ret_t ret_q[$];

  // Engines that should see the returns of the current test
  logic [1:0] exp_route = 2'b00;

  logic reset_seen = 1'b0;
  logic ready_live = 1'b0;
  int   test_errors = 0;
  int   error_count = 0;
  int   tests_run = 0;
  int   tests_failed = 0;

  task automatic report_fail(input string msg);
    $display("FAIL %0t: %s", $time, msg);
    test_errors++;
    error_count++;
  endtask

  task automatic check_requests();
    logic       exp_val;
    logic [1:0] exp_rdy;
    exp_val = (icache_q.size() > 0) || (dcache_q.size() > 0);
    exp_rdy[piton_l15_pkg::ENGINE_ICACHE] = ready_live
                                          && (icache_q.size() < piton_l15_pkg::REQ_FIFO_ELS);
    exp_rdy[piton_l15_pkg::ENGINE_DCACHE] = ready_live
                                          && (dcache_q.size() < piton_l15_pkg::REQ_FIFO_ELS);
    if (l15_val_o !== exp_val) begin
      report_fail($sformatf("l15_val_o is %b, expected %b", l15_val_o, exp_val));
    end
    if (engine_req_ready_o !== exp_rdy) begin
      report_fail($sformatf("request ready is %b, expected %b", engine_req_ready_o, exp_rdy));
    end
    if (l15_val_o && l15_ack_i && exp_val) begin
      // Data engine wins whenever its queue holds an entry
      if (dcache_q.size() > 0) begin
        if (l15_req_o !== dcache_q[0]) report_fail("granted packet differs from dcache head");
        void'(dcache_q.pop_front());
      end else begin
        if (l15_req_o !== icache_q[0]) report_fail("granted packet differs from icache head");
        void'(icache_q.pop_front());
      end
    end
    if (engine_req_v_i[piton_l15_pkg::ENGINE_ICACHE]
        && engine_req_ready_o[piton_l15_pkg::ENGINE_ICACHE]) begin
      icache_q.push_back(engine_req_i[piton_l15_pkg::ENGINE_ICACHE]);
    end
    if (engine_req_v_i[piton_l15_pkg::ENGINE_DCACHE]
        && engine_req_ready_o[piton_l15_pkg::ENGINE_DCACHE]) begin
      dcache_q.push_back(engine_req_i[piton_l15_pkg::ENGINE_DCACHE]);
    end
  endtask

  task automatic check_returns();
    logic [1:0] exp_v;
    logic       exp_ack;
    exp_v = (ret_q.size() > 0) ? exp_route : 2'b00;
    exp_ack = l15_val_i && ready_live && (ret_q.size() < piton_l15_pkg::RET_FIFO_ELS);
    if (engine_ret_v_o !== exp_v) begin
      report_fail($sformatf("engine_ret_v_o is %b, expected %b", engine_ret_v_o, exp_v));
    end
    if ((ret_q.size() > 0) && (engine_ret_o !== ret_q[0])) begin
      report_fail("engine_ret_o differs from the oldest accepted return");
    end
    if (l15_req_ack_o !== exp_ack) begin
      report_fail($sformatf("l15_req_ack_o is %b, expected %b", l15_req_ack_o, exp_ack));
    end
    // One pop per cycle, even when both engines take it
    if (|(engine_ret_yumi_i & exp_v)) void'(ret_q.pop_front());
    if (exp_ack) ret_q.push_back(l15_ret_i);
  endtask

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      icache_q.delete();
      dcache_q.delete();
      ret_q.delete();
      if (reset_seen && (l15_val_o || (|engine_ret_v_o) || (|engine_req_ready_o))) begin
        report_fail("an output is high during reset");
      end
      reset_seen <= 1'b1;
      ready_live <= 1'b0;
    end else begin
      check_requests();
      check_returns();
      ready_live <= 1'b1;
    end
  end

  task automatic expect_route(input logic [1:0] route);
    exp_route = route;
  endtask

  task automatic end_test(input int num);
    if (icache_q.size() + dcache_q.size() + ret_q.size() != 0) begin
      report_fail("entries left in the queues at the end of the test");
    end
    tests_run++;
    if (test_errors == 0) begin
      $display("test %0d: ok", num);
    end else begin
      $display("test %0d: %0d errors", num, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  task automatic print_summary();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
  endtask

endmodule

//--- src/l15_transducer_top.sv
`timescale 1ns/1ns

module l15_transducer_top (
  input  logic                                                     clk_i,
  input  logic                                                     rst_n_i,

  // Engine requests
  input  piton_l15_pkg::l15_req_t [piton_l15_pkg::NUM_ENGINES-1:0] engine_req_i,
  input  logic [piton_l15_pkg::NUM_ENGINES-1:0]                    engine_req_v_i,
  output logic [piton_l15_pkg::NUM_ENGINES-1:0]                    engine_req_ready_o,

  // Request port toward the L1.5
  output piton_l15_pkg::l15_req_t                                  l15_req_o,
  output logic                                                     l15_val_o,
  input  logic                                                     l15_ack_i,

  // Returns from the L1.5
  input  piton_l15_pkg::l15_ret_t                                  l15_ret_i,
  input  logic                                                     l15_val_i,
  output logic                                                     l15_req_ack_o,

  // Returns toward the engines
  output piton_l15_pkg::l15_ret_t                                  engine_ret_o,
  output logic [piton_l15_pkg::NUM_ENGINES-1:0]                    engine_ret_v_o,
  input  logic [piton_l15_pkg::NUM_ENGINES-1:0]                    engine_ret_yumi_i
);

  piton_l15_pkg::l15_req_t [piton_l15_pkg::NUM_ENGINES-1:0] req_head;
  logic [piton_l15_pkg::NUM_ENGINES-1:0]                    req_head_v;
  logic [piton_l15_pkg::NUM_ENGINES-1:0]                    req_yumi;

  piton_l15_pkg::l15_ret_t ret_head;
  logic                    ret_head_v;
  logic                    ret_yumi;
  logic                    ret_ready;

  // One request queue per engine
  for (genvar i = 0; i < piton_l15_pkg::NUM_ENGINES; i++) begin : g_req_fifo
    l15_fifo #(
      .ELS (piton_l15_pkg::REQ_FIFO_ELS),
      .T   (piton_l15_pkg::l15_req_t)
    ) u_req_fifo (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .data_i  (engine_req_i[i]),
      .v_i     (engine_req_v_i[i]),
      .ready_o (engine_req_ready_o[i]),
      .data_o  (req_head[i]),
      .v_o     (req_head_v[i]),
      .yumi_i  (req_yumi[i])
    );
  end

  l15_req_arbiter u_req_arbiter (
    .head_i    (req_head),
    .head_v_i  (req_head_v),
    .yumi_o    (req_yumi),
    .l15_req_o (l15_req_o),
    .l15_val_o (l15_val_o),
    .l15_ack_i (l15_ack_i)
  );

  // Returns are acked in the cycle they arrive if there is room
  assign l15_req_ack_o = l15_val_i & ret_ready;

  l15_fifo #(
    .ELS (piton_l15_pkg::RET_FIFO_ELS),
    .T   (piton_l15_pkg::l15_ret_t)
  ) u_ret_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .data_i  (l15_ret_i),
    .v_i     (l15_val_i),
    .ready_o (ret_ready),
    .data_o  (ret_head),
    .v_o     (ret_head_v),
    .yumi_i  (ret_yumi)
  );

  l15_ret_router u_ret_router (
    .ret_i         (ret_head),
    .ret_v_i       (ret_head_v),
    .fifo_yumi_o   (ret_yumi),
    .engine_v_o    (engine_ret_v_o),
    .engine_yumi_i (engine_ret_yumi_i)
  );

  // Both engines share the same return payload
  assign engine_ret_o = ret_head;

endmodule

//--- src/l15_ret_router.sv
`timescale 1ns/1ns

module l15_ret_router (
  // Head of the return queue
  input  piton_l15_pkg::l15_ret_t                   ret_i,
  input  logic                                      ret_v_i,
  output logic                                      fifo_yumi_o,

  // Per-engine handshake
  output logic [piton_l15_pkg::NUM_ENGINES-1:0]     engine_v_o,
  input  logic [piton_l15_pkg::NUM_ENGINES-1:0]     engine_yumi_i
);

  logic to_icache;
  logic to_dcache;

  // Loads, store acks and atomics belong to the data side only
  function automatic logic icache_sees(input piton_l15_pkg::l15_rtntype_t rtntype);
    return !((rtntype == piton_l15_pkg::RTN_LOAD)
          || (rtntype == piton_l15_pkg::RTN_ST_ACK)
          || (rtntype == piton_l15_pkg::RTN_ATOMIC));
  endfunction

  // Only instruction fills stay away from the data side
  function automatic logic dcache_sees(input piton_l15_pkg::l15_rtntype_t rtntype);
    return rtntype != piton_l15_pkg::RTN_IFILL;
  endfunction

  assign to_icache = icache_sees(ret_i.rtntype);
  assign to_dcache = dcache_sees(ret_i.rtntype);

  always_comb begin
    engine_v_o = '0;
    engine_v_o[piton_l15_pkg::ENGINE_ICACHE] = ret_v_i & to_icache;
    engine_v_o[piton_l15_pkg::ENGINE_DCACHE] = ret_v_i & to_dcache;
  end

  // Either engine may consume a shared return, one pop is enough
  assign fifo_yumi_o = |(engine_yumi_i & engine_v_o);

endmodule

//--- src/l15_req_arbiter.sv
`timescale 1ns/1ns

module l15_req_arbiter (
  // Heads of the per-engine request queues
  input  piton_l15_pkg::l15_req_t [piton_l15_pkg::NUM_ENGINES-1:0] head_i,
  input  logic [piton_l15_pkg::NUM_ENGINES-1:0]                    head_v_i,
  output logic [piton_l15_pkg::NUM_ENGINES-1:0]                    yumi_o,

  // Single request port of the L1.5
  output piton_l15_pkg::l15_req_t                                  l15_req_o,
  output logic                                                     l15_val_o,
  input  logic                                                     l15_ack_i
);

  localparam int REQ_W = $bits(piton_l15_pkg::l15_req_t);

  logic [piton_l15_pkg::NUM_ENGINES-1:0] grant;
  logic [REQ_W-1:0]                      req_sel;

  // Fixed priority, dcache wins whenever it has an entry
  always_comb begin
    grant = '0;
    grant[piton_l15_pkg::ENGINE_DCACHE] = head_v_i[piton_l15_pkg::ENGINE_DCACHE];
    grant[piton_l15_pkg::ENGINE_ICACHE] = head_v_i[piton_l15_pkg::ENGINE_ICACHE]
                                        & ~head_v_i[piton_l15_pkg::ENGINE_DCACHE];
  end

  // One-hot select of the granted head
  always_comb begin
    req_sel = '0;
    for (int i = 0; i < piton_l15_pkg::NUM_ENGINES; i++) begin
      req_sel = req_sel | ({REQ_W{grant[i]}} & head_i[i]);
    end
  end

  assign l15_req_o = piton_l15_pkg::l15_req_t'(req_sel);
  assign l15_val_o = |grant;

  // Ack consumes only the granted entry
  assign yumi_o = grant & {piton_l15_pkg::NUM_ENGINES{l15_ack_i}};

endmodule

//--- src/l15_fifo.sv
`timescale 1ns/1ns

module l15_fifo #(
  parameter int  ELS = 4,
  parameter type T   = logic
) (
  input  logic clk_i,
  input  logic rst_n_i,

  input  T     data_i,
  input  logic v_i,
  output logic ready_o,

  output T     data_o,
  output logic v_o,
  input  logic yumi_i
);

  typedef logic [$clog2(ELS)-1:0]   ptr_t;
  typedef logic [$clog2(ELS+1)-1:0] cnt_t;

  T     mem [ELS];
  ptr_t wr_ptr_q;
  ptr_t rd_ptr_q;
  cnt_t count_q;
  cnt_t count_next;
  logic ready_q;
  logic wr_en;
  logic rd_en;

  assign wr_en = v_i & ready_q;
  assign rd_en = yumi_i & v_o;

  always_comb begin
    case ({wr_en, rd_en})
      2'b10:   count_next = count_q + 1'b1;
      2'b01:   count_next = count_q - 1'b1;
      default: count_next = count_q;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      ready_q  <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(ELS - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(ELS - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_next;
      // Registered full flag, so ready stays low through reset
      ready_q <= (count_next != cnt_t'(ELS));
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  // Head is read straight from storage, no bypass
  assign data_o  = mem[rd_ptr_q];
  assign v_o     = (count_q != '0);
  assign ready_o = ready_q;

endmodule

//--- src/piton_l15_pkg.sv
package piton_l15_pkg;

  // Field widths on the L1.5 interface
  localparam int ADDR_W       = 40;
  localparam int DWORD_W      = 64;
  localparam int RQTYPE_W     = 5;
  localparam int RTNTYPE_W    = 4;
  localparam int INVAL_ADDR_W = 12;

  typedef logic [ADDR_W-1:0]    l15_addr_t;
  typedef logic [DWORD_W-1:0]   l15_dword_t;
  typedef logic [RQTYPE_W-1:0]  l15_rqtype_t;
  typedef logic [RTNTYPE_W-1:0] l15_rtntype_t;

  // Return type codes as sent by the L1.5
  localparam l15_rtntype_t RTN_LOAD   = 4'd0;
  localparam l15_rtntype_t RTN_IFILL  = 4'd1;
  localparam l15_rtntype_t RTN_EVICT  = 4'd3;
  localparam l15_rtntype_t RTN_ST_ACK = 4'd4;
  localparam l15_rtntype_t RTN_INT    = 4'd7;
  localparam l15_rtntype_t RTN_ATOMIC = 4'd13;

  // Queue depths
  localparam int REQ_FIFO_ELS = 4;
  localparam int RET_FIFO_ELS = 16;

  // Engine indices, icache at the low end
  localparam int NUM_ENGINES   = 2;
  localparam int ENGINE_ICACHE = 0;
  localparam int ENGINE_DCACHE = 1;

  // Engine to L1.5 request
  typedef struct packed {
    l15_rqtype_t rqtype;
    logic        nc;
    logic [2:0]  size;
    l15_addr_t   address;
    l15_dword_t  data;
    logic [1:0]  l1rplway;
    logic [3:0]  amo_op;
  } l15_req_t;

  // L1.5 to engine return
  typedef struct packed {
    l15_rtntype_t            rtntype;
    logic                    noncacheable;
    logic                    atomic;
    logic                    threadid;
    l15_dword_t              data_0;
    l15_dword_t              data_1;
    l15_dword_t              data_2;
    l15_dword_t              data_3;
    logic [INVAL_ADDR_W-1:0] inval_address_15_4;
    logic                    inval_icache_inval;
    logic                    inval_dcache_inval;
    logic                    inval_icache_all_way;
    logic                    inval_dcache_all_way;
    logic [1:0]              inval_way;
  } l15_ret_t;

endpackage
